// File: Makefile
# Verilator build and run for the ball tracker
VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= ball_tracker_tb
RTL_TOP   ?= ball_tracker_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -o V$(TB_TOP)

run: build
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "result: FAIL"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "result: FAIL, run ended early"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
+incdir+include
src/ball_tracker_pkg.sv
src/pixel_stream_reg.sv
src/ball_classifier.sv
src/ball_span_tracker.sv
src/pixel_highlighter.sv
src/drive_command.sv
src/ball_tracker_top.sv
verification/ball_tracker_tb.sv

// File: src/ball_classifier.sv
`timescale 1ns/1ps

module ball_classifier import ball_tracker_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,
	input  pixel_t    pixel,
	input  logic      sop,
	input  logic      pixel_step, // word in the decode stage is moving on
	output ball_vec_t confirmed
);

	chan_t       value, min_c, sat, hue;
	logic [31:0] r32, g32, b32;
	logic [31:0] delta, hue_num;
	logic        sheen, mag, rim, red_band, pink_low;
	ball_vec_t   detect;                 // raw per-pixel detections

	function automatic logic in_band(chan_t x, chan_t lo, chan_t hi);
		return (x >= lo) && (x <= hi);
	endfunction

	////////////////////
	// rgb to hsv
	////////////////////
	assign r32 = 32'(pixel.r);
	assign g32 = 32'(pixel.g);
	assign b32 = 32'(pixel.b);

	always_comb begin
		value = (pixel.r > pixel.g) ? ((pixel.r > pixel.b) ? pixel.r : pixel.b)
			: ((pixel.g > pixel.b) ? pixel.g : pixel.b);
		min_c = (pixel.r < pixel.g) ? ((pixel.r < pixel.b) ? pixel.r : pixel.b)
			: ((pixel.g < pixel.b) ? pixel.g : pixel.b);
		delta = 32'(value) - 32'(min_c);
		// black has no saturation
		sat = (value == 8'd0) ? 8'd0 : chan_t'((delta * 32'd255) / 32'(value));
		// wrapped differences stay correct mod 2^32 since every true sum is positive
		if (value != pixel.r) begin
			if (value != pixel.g)
				hue_num = 32'd240 * delta + 32'd60 * (r32 - g32); // blue is max
			else
				hue_num = 32'd120 * delta + 32'd60 * (b32 - r32); // green is max
		end else if (pixel.b < pixel.g) begin
			hue_num = 32'd60 * (g32 - b32);                       // red max, yellow side
		end else begin
			hue_num = 32'd360 * delta + 32'd60 * (g32 - b32);     // red max, magenta side
		end
		// grey pixels get hue 0, result halved to fit a byte
		hue = (delta == 32'd0) ? 8'd0 : chan_t'((hue_num / delta) >> 1);
	end

	////////////////////
	// colour rules
	////////////////////
	assign sheen = (value > shine_v && sat > shine_s_lo && sat < shine_s_hi)
		|| (value > glow_v && sat > glow_s);
	assign mag      = in_band(hue, hue_mag_lo, hue_top);
	assign rim      = in_band(hue, hue_rim_lo, hue_top);
	assign red_band = in_band(hue, red_hue_lo, red_hue_hi);
	assign pink_low = hue <= pink_hue_hi;

	always_comb begin
		detect[ball_red] = ((mag || red_band) && sat > red_sat_min && value > bright_v)
			|| (red_band && sheen)
			|| ((rim || red_band) && ((value > red_sat_min && sat > red_dim_hi)
				|| (sat > red_sat_min && value > red_dim_hi)));
		detect[ball_orange] = (in_band(hue, orange_a_lo, orange_a_hi)
				&& sat > orange_a_s && value > orange_a_v)
			|| (in_band(hue, orange_b_lo, orange_b_hi)
				&& ((value > orange_b_v && sat > orange_b_s)
				|| (sat >= orange_c_s && value > orange_c_v)
				|| (value > orange_d_v && sat > orange_d_s)));
		detect[ball_teal] = in_band(hue, teal_hue_lo, teal_hue_hi)
			&& sat > teal_sv_lo && value > teal_sv_lo
			&& sat < teal_sv_hi && value < teal_sv_hi;
		detect[ball_pink] = ((in_band(hue, pink_hue_lo, hue_top) || pink_low)
				&& sat > pink_bright_s && value > bright_v)
			|| (pink_low && sheen)
			|| (mag && ((sat >= pink_pale_s && value >= pink_pale_v)
				|| (sat >= pink_deep_s && value >= pink_deep_v)))
			|| ((mag || hue <= pink_dim_hue) && sat > pink_dark_s_lo && sat <= pink_dark_s_hi
				&& value >= pink_dark_v_lo && value <= pink_dark_v_hi)
			|| ((rim || pink_low) && ((value > pink_mid_v && sat > pink_deep_s)
				|| (sat > pink_soft_s && value > pink_soft_v)));
	end

	////////////////////
	// run filter
	////////////////////
	for (genvar i = 0; i < num_balls; i++) begin : g_run
		localparam int depth = run_len[i] - 1; // previous detections to remember
		logic [depth-1:0] hist;

		always_ff @(posedge clk) begin
			if (!reset_n) begin
				hist <= '0;
			end else if (pixel_step) begin
				if (sop)
					hist <= '0;                            // new packet, forget old runs
				else
					hist <= {hist[depth-2:0], detect[i]}; // newest in bit 0
			end
		end

		assign confirmed[i] = detect[i] && (&hist);
	end

endmodule

// File: src/ball_span_tracker.sv
`timescale 1ns/1ps

module ball_span_tracker import ball_tracker_pkg::*; (
	input  logic      clk,
	input  logic      reset_n,
	input  logic      sop,
	input  logic      eop,
	input  pixel_t    pixel,
	input  logic      pixel_step,
	input  ball_vec_t confirmed,
	output col_t      column,                // column of the word now in the stage
	output logic      packet_video,
	output col_t      span_min [num_balls],  // latched at the end of a video frame
	output col_t      span_max [num_balls],
	output logic      frame_done
);

	localparam col_t col_last = col_t'(image_w - 1);

	col_t run_min [num_balls];               // spans of the frame in progress
	col_t run_max [num_balls];
	col_t min_next [num_balls];
	col_t max_next [num_balls];

	// fold the current pixel into the running spans
	always_comb begin
		for (int c = 0; c < num_balls; c++) begin
			min_next[c] = run_min[c];
			max_next[c] = run_max[c];
			if (confirmed[c]) begin
				if (column < run_min[c]) min_next[c] = column;
				if (column > run_max[c]) max_next[c] = column;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			column       <= '0;
			packet_video <= 1'b0;
			frame_done   <= 1'b0;
			for (int c = 0; c < num_balls; c++) begin
				run_min[c]  <= col_last; // empty span
				run_max[c]  <= '0;
				span_min[c] <= col_last;
				span_max[c] <= '0;
			end
		end else begin
			frame_done <= pixel_step && eop && packet_video;
			if (pixel_step) begin
				if (sop) begin
					column       <= '0;
					packet_video <= (pixel.b[3:0] == 4'h0); // type nibble 0 is video
					for (int c = 0; c < num_balls; c++) begin
						run_min[c] <= col_last;
						run_max[c] <= '0;
					end
				end else begin
					column <= (column == col_last) ? '0 : col_t'(column + 1'b1);
					for (int c = 0; c < num_balls; c++) begin
						run_min[c] <= min_next[c];
						run_max[c] <= max_next[c];
					end
				end
				// eop pixel itself counts toward the frame
				if (eop && packet_video) begin
					for (int c = 0; c < num_balls; c++) begin
						span_min[c] <= min_next[c];
						span_max[c] <= max_next[c];
					end
				end
			end
		end
	end

	// min and max move together, so a latched span is ordered or still empty
	for (genvar c = 0; c < num_balls; c++) begin : g_chk
		a_span_order: assert property (
			@(posedge clk) disable iff (!reset_n)
			(span_min[c] <= span_max[c]) || (span_min[c] == col_last && span_max[c] == '0)
		);
	end

endmodule

// File: src/ball_tracker_pkg.sv
package ball_tracker_pkg;

	////////////////////
	// stream and frame geometry
	////////////////////
	localparam int image_w = 640;             // pixels per video line

	typedef logic [10:0] col_t;               // column index
	typedef logic [7:0]  chan_t;              // one colour channel or hsv component

	typedef struct packed {
		chan_t r;
		chan_t g;
		chan_t b;
	} pixel_t;                                // 24-bit rgb

	typedef struct packed {
		pixel_t pix;
		logic   sop;
		logic   eop;
	} pixel_word_t;                           // word carried by the stream stages

	////////////////////
	// ball colours
	////////////////////
	typedef enum logic [1:0] {
		ball_red    = 2'd0,
		ball_orange = 2'd1,
		ball_teal   = 2'd2,
		ball_pink   = 2'd3
	} ball_e;                                 // also the colour code in the data word

	localparam int num_balls = 4;
	typedef logic [num_balls-1:0] ball_vec_t; // one flag per colour, indexed by ball_e

	// consecutive detections needed before a pixel counts, teal is less strict
	localparam int run_len [num_balls] = '{4, 4, 3, 4};

	// highlight colours, same order as ball_e
	localparam pixel_t marker_colour [num_balls] = '{24'hff1000, 24'hea9e1b, 24'h04bd42, 24'hdf55e2};

	////////////////////
	// detection thresholds (hue is in half degrees, 0..180)
	////////////////////
	localparam chan_t hue_top        = 8'd180; // top of the hue wheel
	localparam chan_t hue_mag_lo     = 8'd160; // magenta side of red
	localparam chan_t hue_rim_lo     = 8'd172; // narrow band just below the wrap
	localparam chan_t bright_v       = 8'd245;
	localparam chan_t shine_v        = 8'd229; // specular highlight on a ball
	localparam chan_t shine_s_lo     = 8'd17;
	localparam chan_t shine_s_hi     = 8'd155;
	localparam chan_t glow_v         = 8'd210;
	localparam chan_t glow_s         = 8'd130;
	localparam chan_t red_hue_lo     = 8'd3;
	localparam chan_t red_hue_hi     = 8'd10;
	localparam chan_t red_sat_min    = 8'd60;
	localparam chan_t red_dim_hi     = 8'd80;
	localparam chan_t orange_a_lo    = 8'd16;
	localparam chan_t orange_a_hi    = 8'd25;
	localparam chan_t orange_a_s     = 8'd133;
	localparam chan_t orange_a_v     = 8'd78;
	localparam chan_t orange_b_lo    = 8'd23;
	localparam chan_t orange_b_hi    = 8'd30;
	localparam chan_t orange_b_v     = 8'd155;
	localparam chan_t orange_b_s     = 8'd127;
	localparam chan_t orange_c_s     = 8'd153;
	localparam chan_t orange_c_v     = 8'd252;
	localparam chan_t orange_d_v     = 8'd41;
	localparam chan_t orange_d_s     = 8'd247;
	localparam chan_t teal_hue_lo    = 8'd40;
	localparam chan_t teal_hue_hi    = 8'd85;
	localparam chan_t teal_sv_lo     = 8'd50;  // teal needs mid saturation and value
	localparam chan_t teal_sv_hi     = 8'd150;
	localparam chan_t pink_hue_lo    = 8'd150;
	localparam chan_t pink_hue_hi    = 8'd6;   // pink wraps past zero
	localparam chan_t pink_dim_hue   = 8'd4;
	localparam chan_t pink_bright_s  = 8'd84;
	localparam chan_t pink_pale_s    = 8'd76;
	localparam chan_t pink_pale_v    = 8'd249;
	localparam chan_t pink_deep_s    = 8'd102;
	localparam chan_t pink_deep_v    = 8'd140;
	localparam chan_t pink_dark_s_lo = 8'd140; // pink in shadow
	localparam chan_t pink_dark_s_hi = 8'd179;
	localparam chan_t pink_dark_v_lo = 8'd89;
	localparam chan_t pink_dark_v_hi = 8'd106;
	localparam chan_t pink_mid_v     = 8'd105;
	localparam chan_t pink_soft_s    = 8'd82;
	localparam chan_t pink_soft_v    = 8'd168;

	////////////////////
	// distance estimate and steering
	////////////////////
	typedef logic [15:0] dist_t;
	typedef logic [15:0] drive_t;

	localparam int unsigned focal_const    = 7443;
	localparam int unsigned ratio_num      = 79;  // ball size over sensor pitch, 3.95
	localparam int unsigned ratio_den      = 20;
	localparam int unsigned width_knee     = 97;  // wide spans need lens correction
	localparam int unsigned knee_slope_num = 5;
	localparam int unsigned knee_slope_den = 16;
	localparam int unsigned dist_scale     = 10;

	localparam col_t  edge_right = 11'd600;
	localparam col_t  edge_left  = 11'd40;
	localparam dist_t dist_far   = 16'd30;
	localparam dist_t dist_near  = 16'd26;

	localparam drive_t cmd_rotate_right = 16'h0800;
	localparam drive_t cmd_rotate_left  = 16'h1000;
	localparam drive_t cmd_forward      = 16'h4000;
	localparam drive_t cmd_backward     = 16'h2000;

endpackage

// File: src/ball_tracker_top.sv
`timescale 1ns/1ps

module ball_tracker_top import ball_tracker_pkg::*; (
	input  logic   clk,
	input  logic   reset_n,
	// video in
	input  pixel_t sink_data,
	input  logic   sink_valid,
	output logic   sink_ready,
	input  logic   sink_sop,
	input  logic   sink_eop,
	// video out
	output pixel_t source_data,
	output logic   source_valid,
	input  logic   source_ready,
	output logic   source_sop,
	output logic   source_eop,
	// control and drive
	input  logic   mode,
	output drive_t outbuffer
);

	pixel_word_t in_word;      // word in the decode stage
	pixel_word_t out_word;
	logic        in_valid;
	logic        out_ready;
	logic        pixel_step;   // decode-stage word advances
	pixel_t      pixel_hl;
	ball_vec_t   confirmed;
	logic        packet_video;
	col_t        span_min [num_balls];
	col_t        span_max [num_balls];
	logic        frame_done;

	assign pixel_step = in_valid && out_ready;

	pixel_stream_reg in_reg (
		.clk       (clk),
		.reset_n   (reset_n),
		.valid_in  (sink_valid),
		.ready_in  (sink_ready),
		.data_in   ({sink_data, sink_sop, sink_eop}),
		.valid_out (in_valid),
		.ready_out (out_ready),
		.data_out  (in_word)
	);

	ball_classifier u_classifier (
		.clk        (clk),
		.reset_n    (reset_n),
		.pixel      (in_word.pix),
		.sop        (in_word.sop),
		.pixel_step (pixel_step),
		.confirmed  (confirmed)
	);

	ball_span_tracker u_span (
		.clk          (clk),
		.reset_n      (reset_n),
		.sop          (in_word.sop),
		.eop          (in_word.eop),
		.pixel        (in_word.pix),
		.pixel_step   (pixel_step),
		.confirmed    (confirmed),
		.column       (),
		.packet_video (packet_video),
		.span_min     (span_min),
		.span_max     (span_max),
		.frame_done   (frame_done)
	);

	pixel_highlighter u_highlight (
		.pixel        (in_word.pix),
		.sop          (in_word.sop),
		.packet_video (packet_video),
		.mode         (mode),
		.confirmed    (confirmed),
		.pixel_out    (pixel_hl)
	);

	pixel_stream_reg out_reg (
		.clk       (clk),
		.reset_n   (reset_n),
		.valid_in  (in_valid),
		.ready_in  (out_ready),
		.data_in   ({pixel_hl, in_word.sop, in_word.eop}),
		.valid_out (source_valid),
		.ready_out (source_ready),
		.data_out  (out_word)
	);

	drive_command u_drive (
		.clk        (clk),
		.reset_n    (reset_n),
		.frame_done (frame_done),
		.span_min   (span_min),
		.span_max   (span_max),
		.outbuffer  (outbuffer)
	);

	assign source_data = out_word.pix;
	assign source_sop  = out_word.sop;
	assign source_eop  = out_word.eop;

endmodule

// File: src/drive_command.sv
`timescale 1ns/1ps

module drive_command import ball_tracker_pkg::*; (
	input  logic   clk,
	input  logic   reset_n,
	input  logic   frame_done,
	input  col_t   span_min [num_balls],
	input  col_t   span_max [num_balls],
	output drive_t outbuffer
);

	dist_t  dist_q [num_balls]; // per-colour distance of the last frame
	logic   dist_valid;         // distances loaded, command due next edge
	logic   found;
	ball_e  nearest;
	dist_t  best;
	drive_t cmd;

	// distance from apparent width, integer math left to right
	function automatic dist_t estimate(col_t lo, col_t hi);
		logic [31:0] width;
		logic [31:0] focal;
		if (hi <= lo) return '0; // empty span or a single column
		width = 32'(hi - lo);
		focal = focal_const;
		if (width >= width_knee)
			focal = focal - (width - width_knee) * knee_slope_num / knee_slope_den;
		return dist_t'(focal * ratio_num / ratio_den / width / dist_scale);
	endfunction

	////////////////////
	// stage 1 distances
	////////////////////
	always_ff @(posedge clk) begin
		if (frame_done) begin
			for (int c = 0; c < num_balls; c++) begin
				dist_q[c] <= estimate(span_min[c], span_max[c]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) dist_valid <= 1'b0;
		else          dist_valid <= frame_done;
	end

	// nearest ball, strict compare keeps the lower colour on a tie
	always_comb begin
		found   = 1'b0;
		nearest = ball_red;
		best    = '0;
		for (int c = 0; c < num_balls; c++) begin
			if (dist_q[c] != '0 && (!found || dist_q[c] < best)) begin
				found   = 1'b1;
				nearest = ball_e'(c);
				best    = dist_q[c];
			end
		end
	end

	////////////////////
	// stage 2 command
	////////////////////
	always_comb begin
		if (!found)
			cmd = cmd_rotate_right;                // nothing seen, search
		else if (span_min[nearest] > edge_right)
			cmd = cmd_rotate_right;                // ball off to the right
		else if (span_max[nearest] < edge_left)
			cmd = cmd_rotate_left;
		else if (best > dist_far)
			cmd = cmd_forward;
		else if (best < dist_near)
			cmd = cmd_backward;
		else
			cmd = {1'b1, best[4:0], 1'b0, nearest, 7'h0}; // in range, report distance and colour
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			outbuffer <= '0;
		end else if (dist_valid) begin
			outbuffer <= cmd;
		end
	end

endmodule

// File: src/pixel_highlighter.sv
`timescale 1ns/1ps

module pixel_highlighter import ball_tracker_pkg::*; (
	input  pixel_t    pixel,
	input  logic      sop,
	input  logic      packet_video,
	input  logic      mode,       // 1 shows the detections
	input  ball_vec_t confirmed,
	output pixel_t    pixel_out
);

	chan_t  grey;
	pixel_t marked;

	// cheap luma, green weighted double, max 253 so no overflow
	assign grey = chan_t'(pixel.g[7:1] + pixel.r[7:2] + pixel.b[7:2]);

	////////////////////
	// marker priority
	////////////////////
	always_comb begin
		if (confirmed[ball_red])
			marked = marker_colour[ball_red];
		else if (confirmed[ball_teal])
			marked = marker_colour[ball_teal];
		else if (confirmed[ball_orange])
			marked = marker_colour[ball_orange];
		else if (confirmed[ball_pink])
			marked = marker_colour[ball_pink];
		else
			marked = '{r: grey, g: grey, b: grey}; // background goes grey
	end

	// sop word is the packet descriptor and non-video data is left alone
	assign pixel_out = (mode && !sop && packet_video) ? marked : pixel;

endmodule

// File: src/pixel_stream_reg.sv
`timescale 1ns/1ps

module pixel_stream_reg import ball_tracker_pkg::*; (
	input  logic        clk,
	input  logic        reset_n,
	// upstream side
	input  logic        valid_in,
	output logic        ready_in,
	input  pixel_word_t data_in,
	// downstream side
	output logic        valid_out,
	input  logic        ready_out,
	output pixel_word_t data_out
);

	// can take a word when empty or when the held word leaves this cycle
	assign ready_in = !valid_out || ready_out;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid_out <= 1'b0;
		end else if (ready_in) begin
			valid_out <= valid_in; // refill or drain
		end
	end

	// payload only loads on a real transfer
	always_ff @(posedge clk) begin
		if (ready_in && valid_in) begin
			data_out <= data_in;
		end
	end

	// a stalled word must stay put until the consumer takes it
	a_hold_stalled: assert property (
		@(posedge clk) disable iff (!reset_n)
		(valid_out && !ready_out) |=> (valid_out && $stable(data_out))
	);

endmodule

// File: include/tb_frame_table.svh
`ifndef tb_frame_table_svh
`define tb_frame_table_svh

////////////////////
// test palette
////////////////////
// raw detections worked out by hand from the hsv rules
// 0 dark grey    hue 0   sat 0   val 32   nothing
// 1 blue         hue 120 sat 255 val 192  nothing
// 2 red          hue 8   sat 255 val 255  red only
// 3 orange       hue 20  sat 255 val 255  orange only
// 4 teal         hue 80  sat 127 val 120  teal only
// 5 pink         hue 155 sat 255 val 255  pink only, below the magenta band
// 6 red-orange   hue 4   sat 255 val 255  red and pink at once
localparam int num_colours = 7;
localparam pixel_t pal_colour [num_colours] = '{
	24'h202020, 24'h0000c0, 24'hff4600, 24'hffaa00, 24'h3c7864, 24'hff00d2, 24'hff2800
};
localparam ball_vec_t pal_detect [num_colours] = '{
	4'b0000, 4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b1001
};

typedef struct packed {
	logic       mode;    // 1 recolours video
	logic [3:0] ptype;   // low blue nibble of the sop word, 0 is video
	logic [2:0] bg;      // palette index of the background
	logic [2:0] ball_a;  // unused ball repeats bg
	col_t       a_lo;
	col_t       a_hi;
	logic [2:0] ball_b;
	col_t       b_lo;
	col_t       b_hi;
	col_t       len;     // pixels after the sop word
	drive_t     drive;   // outbuffer once the packet is through
} frame_row_t;

// columns: mode, type, bg, ball a, lo, hi, ball b, lo, hi, length, drive word
localparam int num_frames = 10;
localparam frame_row_t frame_table [num_frames] = '{
	'{1'b0, 4'h0, 3'd0, 3'd2, 11'd200, 11'd303, 3'd0, 11'd0, 11'd0, 11'd320, 16'hf400},
	'{1'b1, 4'h0, 3'd1, 3'd3, 11'd100, 11'd153, 3'd1, 11'd0, 11'd0, 11'd200, 16'h4000},
	'{1'b1, 4'h0, 3'd0, 3'd4, 11'd10, 11'd30, 3'd0, 11'd0, 11'd0, 11'd100, 16'h1000},
	'{1'b0, 4'h0, 3'd1, 3'd5, 11'd610, 11'd635, 3'd1, 11'd0, 11'd0, 11'd640, 16'h0800},
	'{1'b1, 4'h3, 3'd0, 3'd2, 11'd20, 11'd60, 3'd0, 11'd0, 11'd0, 11'd80, 16'h0800},
	'{1'b1, 4'h0, 3'd0, 3'd2, 11'd100, 11'd299, 3'd4, 11'd350, 11'd452, 11'd480, 16'h2000},
	'{1'b0, 4'h0, 3'd0, 3'd5, 11'd100, 11'd150, 3'd4, 11'd300, 11'd402, 11'd480, 16'hf500},
	'{1'b1, 4'h0, 3'd1, 3'd1, 11'd0, 11'd0, 3'd1, 11'd0, 11'd0, 11'd64, 16'h0800},
	'{1'b1, 4'h0, 3'd0, 3'd2, 11'd50, 11'd153, 3'd5, 11'd300, 11'd403, 11'd420, 16'hf400},
	'{1'b1, 4'h0, 3'd0, 3'd6, 11'd100, 11'd153, 3'd0, 11'd0, 11'd0, 11'd200, 16'h4000}
};
// rows in order: data word red d29, forward, rotate left, rotate right off the edge,
// non-video keeps the word, backward red nearer than teal, data word teal nearer than pink,
// empty frame, tie between red and pink goes to red
// last a ball seen as red and pink together, marked red and driven forward

`endif

// File: verification/ball_tracker_tb.sv
`timescale 1ns/1ps

module ball_tracker_tb import ball_tracker_pkg::*; ();

	localparam int clk_period   = 20;
	localparam int cycle_budget = 8;  // clocks per word, stalls and gaps included
	localparam int row_slack    = 20; // drain and drive word settling per packet

	`include "tb_frame_table.svh"

	logic        clk;
	logic        reset_n;
	pixel_t      sink_data;
	logic        sink_valid;
	logic        sink_ready;
	logic        sink_sop;
	logic        sink_eop;
	pixel_t      source_data;
	logic        source_valid;
	logic        source_ready;
	logic        source_sop;
	logic        source_eop;
	logic        mode;
	drive_t      outbuffer;
	integer      seed = 32'hb67064f0;
	pixel_word_t exp_q [$];           // words still due on the source side
	int          errors;
	int          checks;

	ball_tracker_top dut (
		.clk          (clk),
		.reset_n      (reset_n),
		.sink_data    (sink_data),
		.sink_valid   (sink_valid),
		.sink_ready   (sink_ready),
		.sink_sop     (sink_sop),
		.sink_eop     (sink_eop),
		.source_data  (source_data),
		.source_valid (source_valid),
		.source_ready (source_ready),
		.source_sop   (source_sop),
		.source_eop   (source_eop),
		.mode         (mode),
		.outbuffer    (outbuffer)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	////////////////////
	// reference model
	////////////////////
	function automatic int palette_at(frame_row_t row, int col);
		if (col >= row.a_lo && col <= row.a_hi) return row.ball_a;
		if (col >= row.b_lo && col <= row.b_hi) return row.ball_b;
		return row.bg;
	endfunction

	// red beats teal beats orange beats pink, else grey from the luma mix
	function automatic pixel_t highlight(pixel_t p, ball_vec_t conf);
		chan_t y;
		y = (p.g >> 1) + (p.r >> 2) + (p.b >> 2);
		if (conf[ball_red])    return marker_colour[ball_red];
		if (conf[ball_teal])   return marker_colour[ball_teal];
		if (conf[ball_orange]) return marker_colour[ball_orange];
		if (conf[ball_pink])   return marker_colour[ball_pink];
		return {y, y, y};
	endfunction

	////////////////////
	// stimulus
	////////////////////
	// one word on the sink, returns once the handshake is due on the next edge
	task automatic send_word(input pixel_t p, input logic sop, input logic eop);
		while (($random(seed) & 7) == 0) begin // idle gap
			@(posedge clk);
			sink_valid <= 1'b0;
		end
		@(posedge clk);
		sink_valid <= 1'b1;
		sink_data  <= p;
		sink_sop   <= sop;
		sink_eop   <= eop;
		@(negedge clk);
		while (!sink_ready) @(negedge clk);
	endtask

	task automatic run_frame(input frame_row_t row, input drive_t prev_drive, input int num);
		int          run [num_balls]; // consecutive raw detections per colour
		int          idx;
		ball_vec_t   det;
		ball_vec_t   conf;
		pixel_t      p;
		pixel_word_t w;
		for (int c = 0; c < num_balls; c++) run[c] = 0;
		@(posedge clk);
		mode <= row.mode;                 // stream is empty here
		p = {8'h00, 8'h00, 4'h0, row.ptype};
		w.pix = p;
		w.sop = 1'b1;
		w.eop = 1'b0;
		exp_q.push_back(w);               // descriptor passes untouched
		send_word(p, 1'b1, 1'b0);
		for (int col = 0; col < row.len; col++) begin
			idx = palette_at(row, col);
			p   = pal_colour[idx];
			det = pal_detect[idx];
			for (int c = 0; c < num_balls; c++) begin
				run[c]  = det[c] ? run[c] + 1 : 0;
				conf[c] = run[c] >= run_len[c];
			end
			w.pix = (row.mode && row.ptype == 4'h0) ? highlight(p, conf) : p;
			w.sop = 1'b0;
			w.eop = (col == row.len - 1);
			exp_q.push_back(w);
			send_word(p, 1'b0, w.eop);
		end
		@(posedge clk);
		sink_valid <= 1'b0;
		sink_sop   <= 1'b0;
		sink_eop   <= 1'b0;
		@(negedge clk);
		while (!(source_valid && source_eop)) @(negedge clk); // eop just left the decode stage
		@(negedge clk);                                        // distances loading
		checks++;
		if (outbuffer !== prev_drive) begin
			$display("ERROR outbuffer: got %h expected %h one cycle early in frame %0d",
				outbuffer, prev_drive, num);
			errors++;
		end
		@(negedge clk);                                        // drive word now registered
		checks++;
		if (outbuffer !== row.drive) begin
			$display("ERROR outbuffer: got %h expected %h in frame %0d", outbuffer, row.drive, num);
			errors++;
		end
		while (exp_q.size() != 0) @(negedge clk); // last word handed over
		@(posedge clk);
	endtask

	// source side stalls about a quarter of the time
	initial begin
		@(posedge reset_n);
		forever begin
			@(posedge clk);
			source_ready <= ($random(seed) & 3) != 0;
		end
	end

	////////////////////
	// output monitor
	////////////////////
	always @(negedge clk) begin : monitor
		pixel_word_t w;
		if (reset_n && source_valid && source_ready) begin
			if (exp_q.size() == 0) begin
				$display("extra word on the source side at %0t", $time);
				errors++;
			end else begin
				w = exp_q.pop_front();
				checks++;
				if (source_data !== w.pix) begin
					$display("ERROR source_data: got %h expected %h", source_data, w.pix);
					errors++;
				end
				if (source_sop !== w.sop) begin
					$display("ERROR source_sop: got %h expected %h", source_sop, w.sop);
					errors++;
				end
				if (source_eop !== w.eop) begin
					$display("ERROR source_eop: got %h expected %h", source_eop, w.eop);
					errors++;
				end
			end
		end
	end

	// whole run gets a budget from the table size
	initial begin : watchdog
		longint words;
		longint limit;
		words = 0;
		for (int i = 0; i < num_frames; i++) words += frame_table[i].len + 1;
		limit = (words * cycle_budget + num_frames * row_slack + 10) * clk_period;
		#(limit);
		$display("timeout, the stream stopped moving before all frames were checked");
		$display("Simulation failed");
		$finish;
	end

	////////////////////
	// main sequence
	////////////////////
	initial begin
		sink_data    = '0;
		sink_valid   = 1'b0;
		sink_sop     = 1'b0;
		sink_eop     = 1'b0;
		source_ready = 1'b0;
		mode         = 1'b0;
		reset_n      = 1'b0;
		errors       = 0;
		checks       = 0;
		repeat (5) @(posedge clk);
		reset_n <= 1'b1;
		@(negedge clk);
		checks++;
		if (outbuffer !== 16'h0000) begin
			$display("ERROR outbuffer: got %h expected %h after reset", outbuffer, 16'h0000);
			errors++;
		end
		if (source_valid !== 1'b0) begin
			$display("ERROR source_valid: got %h expected %h after reset", source_valid, 1'b0);
			errors++;
		end
		if (sink_ready !== 1'b1) begin
			$display("ERROR sink_ready: got %h expected %h after reset", sink_ready, 1'b1);
			errors++;
		end
		for (int i = 0; i < num_frames; i++) begin
			run_frame(frame_table[i], (i == 0) ? 16'h0000 : frame_table[i - 1].drive, i);
		end
		repeat (4) @(posedge clk);
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
